// File: all.f
rtl/mem_fifo_pkg.sv
rtl/stream_fifo.sv
rtl/mem_port_fifo.sv
rtl/mem_bank.sv
rtl/mem_fifo_top.sv
tb/mem_fifo_assertions.sv
tb/mem_fifo_tb.sv

// File: rtl/mem_bank.sv
// single-port word memory bank with byte enables, contention input and one-cycle response
`timescale 1ns/1ps
`default_nettype none

module mem_bank
  import mem_fifo_pkg::*;
(
  input  wire logic  clk_i,
  input  wire logic  rst_ni,
  input  wire logic  conflict_i,    // another master owns the bank this cycle
  input  wire logic  mem_req_i,
  input  wire addr_t mem_addr_i,
  input  wire data_t mem_wdata_i,
  input  wire be_t   mem_be_i,
  input  wire logic  mem_we_i,
  output logic       mem_gnt_o,
  output logic       mem_r_valid_o,
  output data_t      mem_r_data_o
);

  localparam int unsigned BYTE_BITS = DW / BW;
  localparam int unsigned WORDS     = 2 ** AW;

  data_t mem_q [WORDS];
  logic  r_valid_q;
  data_t r_data_q;

  // higher-priority master wins, request waits
  assign mem_gnt_o = mem_req_i & ~conflict_i;

  // every grant gets exactly one response a cycle later
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      r_valid_q <= 1'b0;
    else
      r_valid_q <= mem_gnt_o;
  end

  always_ff @(posedge clk_i)
  begin
    if (mem_gnt_o)
    begin
      if (mem_we_i)
      begin
        for (int b = 0; b < BW; b++)
        begin
          if (mem_be_i[b])
            mem_q[mem_addr_i][b*BYTE_BITS +: BYTE_BITS] <=
              mem_wdata_i[b*BYTE_BITS +: BYTE_BITS];   // enabled bytes only
        end
      end
      else
      begin
        r_data_q <= mem_q[mem_addr_i];
      end
    end
  end

  assign mem_r_valid_o = r_valid_q;
  assign mem_r_data_o  = r_data_q;   // stale after a write, unused there

endmodule

`default_nettype wire

// File: rtl/mem_fifo_pkg.sv
// shared widths, word types and queue depth for the memory port queue and bank
`default_nettype none

package mem_fifo_pkg;

  // bank geometry
  localparam int unsigned AW = 10;    // word address, 1024-word bank
  localparam int unsigned DW = 32;    // data word
  localparam int unsigned BW = 4;     // one enable per byte

  // packed request: addr, wdata, be, we from the top bits down
  localparam int unsigned REQ_W = AW + DW + BW + 1;

  // default depth of request and response FIFOs
  localparam int unsigned QUEUE_DEPTH = 4;

  typedef logic [AW-1:0]    addr_t;      // word address
  typedef logic [DW-1:0]    data_t;      // read or write data
  typedef logic [BW-1:0]    be_t;        // byte enables
  typedef logic [REQ_W-1:0] req_word_t;  // request as stored in the FIFO

endpackage

`default_nettype wire

// File: rtl/mem_fifo_top.sv
// top level joining the decoupled requester port to one memory bank
`timescale 1ns/1ps
`default_nettype none

module mem_fifo_top
  import mem_fifo_pkg::*;
(
  input  wire logic  clk_i,
  input  wire logic  rst_ni,
  input  wire logic  clear_i,
  input  wire logic  conflict_i,
  input  wire logic  req_i,
  output logic       gnt_o,
  input  wire addr_t addr_i,
  input  wire data_t wdata_i,
  input  wire be_t   be_i,
  input  wire logic  we_i,
  output logic       r_valid_o,
  output data_t      r_data_o,
  input  wire logic  r_ready_i,
  output logic       empty_o
);

  // port queue to bank
  logic  mem_req;
  logic  mem_gnt;
  addr_t mem_addr;
  data_t mem_wdata;
  be_t   mem_be;
  logic  mem_we;
  logic  mem_r_valid;
  data_t mem_r_data;

  mem_port_fifo u_port (
    .clk_i         ( clk_i       ),
    .rst_ni        ( rst_ni      ),
    .clear_i       ( clear_i     ),
    .empty_o       ( empty_o     ),
    .req_i         ( req_i       ),
    .gnt_o         ( gnt_o       ),
    .addr_i        ( addr_i      ),
    .wdata_i       ( wdata_i     ),
    .be_i          ( be_i        ),
    .we_i          ( we_i        ),
    .r_valid_o     ( r_valid_o   ),
    .r_data_o      ( r_data_o    ),
    .r_ready_i     ( r_ready_i   ),
    .mem_req_o     ( mem_req     ),
    .mem_gnt_i     ( mem_gnt     ),
    .mem_addr_o    ( mem_addr    ),
    .mem_wdata_o   ( mem_wdata   ),
    .mem_be_o      ( mem_be      ),
    .mem_we_o      ( mem_we      ),
    .mem_r_valid_i ( mem_r_valid ),
    .mem_r_data_i  ( mem_r_data  )
  );

  mem_bank u_bank (
    .clk_i         ( clk_i       ),
    .rst_ni        ( rst_ni      ),
    .conflict_i    ( conflict_i  ),
    .mem_req_i     ( mem_req     ),
    .mem_addr_i    ( mem_addr    ),
    .mem_wdata_i   ( mem_wdata   ),
    .mem_be_i      ( mem_be      ),
    .mem_we_i      ( mem_we      ),
    .mem_gnt_o     ( mem_gnt     ),
    .mem_r_valid_o ( mem_r_valid ),
    .mem_r_data_o  ( mem_r_data  )
  );

endmodule

`default_nettype wire

// File: rtl/mem_port_fifo.sv
// decoupling queue for one memory requester port, with request FIFO, response hold and response FIFO
`timescale 1ns/1ps
`default_nettype none

module mem_port_fifo
  import mem_fifo_pkg::*;
(
  input  wire logic  clk_i,
  input  wire logic  rst_ni,
  input  wire logic  clear_i,
  output logic       empty_o,
  // requester side
  input  wire logic  req_i,
  output logic       gnt_o,
  input  wire addr_t addr_i,
  input  wire data_t wdata_i,
  input  wire be_t   be_i,
  input  wire logic  we_i,
  output logic       r_valid_o,
  output data_t      r_data_o,
  input  wire logic  r_ready_i,
  // memory side
  output logic       mem_req_o,
  input  wire logic  mem_gnt_i,
  output addr_t      mem_addr_o,
  output data_t      mem_wdata_o,
  output be_t        mem_be_o,
  output logic       mem_we_o,
  input  wire logic  mem_r_valid_i,
  input  wire data_t mem_r_data_i
);

  req_word_t req_push_data;
  req_word_t req_pop_data;
  logic      req_pop_valid;
  logic      req_empty;

  logic      resp_push_valid;
  data_t     resp_push_data;
  logic      resp_push_ready;
  logic      resp_pop_valid;
  logic      resp_empty;

  logic      hold_valid_q;   // a response is parked outside the FIFO
  data_t     hold_data_q;
  logic      hold_load;

  assign req_push_data = {addr_i, wdata_i, be_i, we_i};

  stream_fifo #(
    .WIDTH ( REQ_W       ),
    .DEPTH ( QUEUE_DEPTH )
  ) i_fifo_req (
    .clk_i        ( clk_i         ),
    .rst_ni       ( rst_ni        ),
    .clear_i      ( clear_i       ),
    .push_valid_i ( req_i         ),
    .push_data_i  ( req_push_data ),
    .push_ready_o ( gnt_o         ),
    .pop_valid_o  ( req_pop_valid ),
    .pop_data_o   ( req_pop_data  ),
    .pop_ready_i  ( mem_gnt_i     ),  // bank grant pops the entry
    .empty_o      ( req_empty     )
  );

  assign {mem_addr_o, mem_wdata_o, mem_be_o, mem_we_o} = req_pop_data;

  // only ask the bank when the answer has somewhere to go
  assign mem_req_o = req_pop_valid & resp_push_ready;

  // held response goes first to keep order
  assign resp_push_valid = hold_valid_q | mem_r_valid_i;
  assign resp_push_data  = hold_valid_q ? hold_data_q : mem_r_data_i;

  // new response not taken by the FIFO this cycle
  assign hold_load = mem_r_valid_i & (hold_valid_q | ~resp_push_ready);

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      hold_valid_q <= 1'b0;
    else if (clear_i)
      hold_valid_q <= 1'b0;
    else if (hold_load)
      hold_valid_q <= 1'b1;
    else if (hold_valid_q && resp_push_ready)
      hold_valid_q <= 1'b0;   // drained into the FIFO
  end

  always_ff @(posedge clk_i)
  begin
    if (hold_load)
      hold_data_q <= mem_r_data_i;
  end

  stream_fifo #(
    .WIDTH ( DW          ),
    .DEPTH ( QUEUE_DEPTH )
  ) i_fifo_resp (
    .clk_i        ( clk_i           ),
    .rst_ni       ( rst_ni          ),
    .clear_i      ( clear_i         ),
    .push_valid_i ( resp_push_valid ),
    .push_data_i  ( resp_push_data  ),
    .push_ready_o ( resp_push_ready ),
    .pop_valid_o  ( resp_pop_valid  ),
    .pop_data_o   ( r_data_o        ),
    .pop_ready_i  ( r_ready_i       ),
    .empty_o      ( resp_empty      )
  );

  assign r_valid_o = resp_pop_valid & r_ready_i;   // marks transfer cycles only
  assign empty_o   = req_empty & resp_empty;

endmodule

`default_nettype wire

// File: rtl/stream_fifo.sv
// circular-buffer FIFO with valid/ready on both sides, used for request and response queues
`timescale 1ns/1ps
`default_nettype none

module stream_fifo
  import mem_fifo_pkg::*;
#(
  parameter int unsigned WIDTH = 32,
  parameter int unsigned DEPTH = QUEUE_DEPTH
)
(
  input  wire logic             clk_i,
  input  wire logic             rst_ni,
  input  wire logic             clear_i,
  input  wire logic             push_valid_i,
  input  wire logic [WIDTH-1:0] push_data_i,
  output logic                  push_ready_o,
  output logic                  pop_valid_o,
  output logic      [WIDTH-1:0] pop_data_o,
  input  wire logic             pop_ready_i,
  output logic                  empty_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             full;
  logic             push;
  logic             pop;

  assign full    = (count_q == CNT_W'(DEPTH));
  assign empty_o = (count_q == '0);

  // a full buffer still takes data when an entry leaves in the same cycle
  assign push_ready_o = ~full | pop_ready_i;
  assign pop_valid_o  = ~empty_o;
  assign pop_data_o   = mem_q[rd_ptr_q];   // registered storage, no fall-through

  assign push = push_valid_i & push_ready_o;
  assign pop  = pop_valid_o & pop_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else if (clear_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      if (pop)
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      if (push && !pop)
        count_q <= count_q + 1'b1;
      else if (pop && !push)
        count_q <= count_q - 1'b1;
    end
  end

  // storage payload
  always_ff @(posedge clk_i)
  begin
    if (push)
      mem_q[wr_ptr_q] <= push_data_i;
  end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Build the memory port queue testbench with Verilator, run it and check the log.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=sim_mem_fifo
LOG=sim.log

verilator --binary --timing --assert \
  -f all.f \
  --top-module mem_fifo_tb \
  -Mdir "$BUILD_DIR" \
  -o "$SIM_BIN"
if [ $? -ne 0 ]; then
  echo "compile step failed"
  exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "Testbench passed" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1

// File: tb/mem_fifo_assertions.sv
// handshake and occupancy assertions for the memory port queue, attached to mem_port_fifo by bind
`timescale 1ns/1ps
`default_nettype none

module mem_fifo_assertions
  import mem_fifo_pkg::*;
(
  input wire logic  clk_i,
  input wire logic  rst_ni,
  input wire logic  clear_i,
  input wire logic  req_i,
  input wire logic  gnt_i,
  input wire logic  mem_req_i,
  input wire logic  resp_ready_i,
  input wire logic  hold_valid_i,
  input wire data_t hold_data_i,
  input wire logic  r_valid_i,
  input wire logic  r_ready_i
);

  int unsigned outstanding_q;   // accepted requests not yet delivered

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      outstanding_q <= 0;
    else if (clear_i)
      outstanding_q <= 0;
    else if (req_i && gnt_i && !r_valid_i)
      outstanding_q <= outstanding_q + 1;
    else if (r_valid_i && !(req_i && gnt_i))
      outstanding_q <= outstanding_q - 1;
  end

  // the bank is only asked when its answer has room in the FIFO or the hold register
  bank_req_room_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_i |=> resp_ready_i || !hold_valid_i)
    else $error("bank answer would find neither response FIFO room nor a free hold register");

  held_resp_kept_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    hold_valid_i && !resp_ready_i && !clear_i |=> hold_valid_i && $stable(hold_data_i))
    else $error("held response changed or vanished before the response FIFO took it");

  // a response needs a ready requester and an accepted request behind it
  resp_valid_ready_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    r_valid_i |-> r_ready_i && outstanding_q != 0)
    else $error("response valid without ready or without an outstanding request");

  // both FIFOs, the hold register and one word in flight at the bank
  outstanding_bound_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    outstanding_q <= 2 * QUEUE_DEPTH + 2)
    else $error("more requests outstanding than the queue can hold");

endmodule

bind mem_port_fifo mem_fifo_assertions u_assertions (
  .clk_i        ( clk_i           ),
  .rst_ni       ( rst_ni          ),
  .clear_i      ( clear_i         ),
  .req_i        ( req_i           ),
  .gnt_i        ( gnt_o           ),
  .mem_req_i    ( mem_req_o       ),
  .resp_ready_i ( resp_push_ready ),
  .hold_valid_i ( hold_valid_q    ),
  .hold_data_i  ( hold_data_q     ),
  .r_valid_i    ( r_valid_o       ),
  .r_ready_i    ( r_ready_i       )
);

`default_nettype wire

// File: tb/mem_fifo_tb.sv
// testbench for mem_fifo_top, runs a request table and checks responses against a reference memory
`timescale 1ns/1ps
`default_nettype none

module mem_fifo_tb
  import mem_fifo_pkg::*;
();

  localparam int CLK_PERIOD      = 100;
  localparam int SEED            = 52053;
  localparam int N_ROWS          = 16;
  localparam int N_APPLIED       = 2 * N_ROWS + 4;   // table once, again under back-pressure, 4 after clear
  localparam int WATCHDOG_CYCLES = N_APPLIED * 40 + 200;
  localparam int STALL_CYCLES    = 4 * N_ROWS;       // longest wait for the grant to drop
  localparam int BYTE_W          = DW / BW;

  typedef struct packed {
    logic  we;
    addr_t addr;
    data_t wdata;
    be_t   be;
  } row_t;

  logic  clk_i = 1'b0;
  logic  rst_ni;
  logic  clear_i;
  logic  conflict_i;
  logic  req_i;
  logic  gnt_o;
  addr_t addr_i;
  data_t wdata_i;
  be_t   be_i;
  logic  we_i;
  logic  r_valid_o;
  data_t r_data_o;
  logic  r_ready_i;
  logic  empty_o;

  row_t  stim [N_ROWS];
  data_t ref_mem [2**AW];
  logic  exp_we_q [$];     // one entry per accepted request
  data_t exp_data_q [$];
  int    sent_count  = 0;
  int    rd_idx      = 0;  // next expected response
  int    errors      = 0;
  int    checks      = 0;
  int    resp_errors = 0;
  int    resp_checks = 0;
  logic  rand_on;
  logic  saw_gnt_drop;

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  mem_fifo_top dut0 (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .clear_i    ( clear_i    ),
    .conflict_i ( conflict_i ),
    .req_i      ( req_i      ),
    .gnt_o      ( gnt_o      ),
    .addr_i     ( addr_i     ),
    .wdata_i    ( wdata_i    ),
    .be_i       ( be_i       ),
    .we_i       ( we_i       ),
    .r_valid_o  ( r_valid_o  ),
    .r_data_o   ( r_data_o   ),
    .r_ready_i  ( r_ready_i  ),
    .empty_o    ( empty_o    )
  );

  task automatic load_table();
    stim[0]  = {1'b1, 10'h010, 32'h1234_5678, 4'hf};
    stim[1]  = {1'b1, 10'h011, 32'hcafe_babe, 4'hf};
    stim[2]  = {1'b0, 10'h010, 32'h0000_0000, 4'h0};
    stim[3]  = {1'b0, 10'h011, 32'h0000_0000, 4'h0};
    stim[4]  = {1'b1, 10'h010, 32'haaaa_aaaa, 4'h3};   // low half only
    stim[5]  = {1'b1, 10'h011, 32'h5555_5555, 4'ha};   // bytes 3 and 1
    stim[6]  = {1'b0, 10'h010, 32'h0000_0000, 4'h0};
    stim[7]  = {1'b0, 10'h011, 32'h0000_0000, 4'h0};
    stim[8]  = {1'b1, 10'h200, 32'h0bad_f00d, 4'hf};
    stim[9]  = {1'b1, 10'h3ff, 32'hc001_d00d, 4'hf};
    stim[10] = {1'b0, 10'h200, 32'h0000_0000, 4'h0};
    stim[11] = {1'b1, 10'h200, 32'h7700_0000, 4'h8};
    stim[12] = {1'b0, 10'h3ff, 32'h0000_0000, 4'h0};
    stim[13] = {1'b0, 10'h200, 32'h0000_0000, 4'h0};
    stim[14] = {1'b1, 10'h000, 32'h1357_9bdf, 4'hf};
    stim[15] = {1'b0, 10'h000, 32'h0000_0000, 4'h0};
  endtask

  // byte-enable merge, then queue what the response must carry
  function automatic void model_accept(input row_t row);
    data_t word;
    word = ref_mem[row.addr];
    if (row.we)
    begin
      for (int b = 0; b < BW; b++)
      begin
        if (row.be[b])
          word[b*BYTE_W +: BYTE_W] = row.wdata[b*BYTE_W +: BYTE_W];
      end
      ref_mem[row.addr] = word;
    end
    exp_we_q.push_back(row.we);
    exp_data_q.push_back(word);
    sent_count++;
  endfunction

  // entered 1 ns after a rising edge, leaves the same way
  task automatic send_request(input row_t row);
    req_i   = 1'b1;
    we_i    = row.we;
    addr_i  = row.addr;
    wdata_i = row.wdata;
    be_i    = row.be;
    @(negedge clk_i);
    while (!gnt_o)
      @(negedge clk_i);
    @(posedge clk_i);
    #1;
    req_i = 1'b0;
    model_accept(row);
  endtask

  task automatic apply_rows(input int first, input int last);
    for (int i = first; i <= last; i++)
      send_request(stim[i]);
  endtask

  task automatic wait_drained();
    @(negedge clk_i);
    while ((rd_idx != exp_we_q.size()) || !empty_o)
      @(negedge clk_i);
    @(posedge clk_i);
    #1;
  endtask

  task automatic jitter_inputs();
    while (rand_on)
    begin
      @(posedge clk_i);
      #1;
      conflict_i = ($urandom % 2) == 0;
      r_ready_i  = ($urandom % 4) != 0;
    end
  endtask

  task automatic release_when_stalled();
    int waited;
    waited = 0;
    @(negedge clk_i);
    while (gnt_o && (waited < STALL_CYCLES))
    begin
      @(negedge clk_i);
      waited++;
    end
    saw_gnt_drop = !gnt_o;
    repeat (3) @(posedge clk_i);
    #1;
    r_ready_i = 1'b1;
  endtask

  // r_valid_o only rises on a transfer, so every hit consumes one expected entry
  always @(negedge clk_i)
  begin
    if (rst_ni && r_valid_o)
    begin
      resp_checks++;
      assert (rd_idx < exp_we_q.size())
      else
      begin
        resp_errors++;
        $display("response at %0t arrived with no request outstanding", $time);
      end
      if (rd_idx < exp_we_q.size())
      begin
        if (!exp_we_q[rd_idx])
        begin
          resp_checks++;
          assert (r_data_o === exp_data_q[rd_idx])
          else
          begin
            resp_errors++;
            $display("FAILED at %0t: response %0d read data %h, expected %h",
                     $time, rd_idx, r_data_o, exp_data_q[rd_idx]);
          end
        end
        rd_idx++;
      end
    end
  end

  initial
  begin
    void'($urandom(SEED));
    rst_ni       = 1'b0;
    clear_i      = 1'b0;
    conflict_i   = 1'b0;
    req_i        = 1'b0;
    addr_i       = '0;
    wdata_i      = '0;
    be_i         = '0;
    we_i         = 1'b0;
    r_ready_i    = 1'b1;
    rand_on      = 1'b0;
    saw_gnt_drop = 1'b0;
    load_table();
    repeat (2) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    @(negedge clk_i);
    checks++;
    assert (gnt_o && empty_o && !r_valid_o)
    else
    begin
      errors++;
      $display("FAILED at %0t: after reset gnt %b empty %b r_valid %b",
               $time, gnt_o, empty_o, r_valid_o);
    end
    @(posedge clk_i);
    #1;

    apply_rows(0, 3);      // full words, read back
    wait_drained();
    apply_rows(4, 7);      // partial writes merged into those words
    wait_drained();

    rand_on = 1'b1;
    fork
      begin
        apply_rows(8, N_ROWS - 1);
        wait_drained();
        rand_on = 1'b0;
      end
      jitter_inputs();
    join
    conflict_i = 1'b0;
    r_ready_i  = 1'b1;

    r_ready_i = 1'b0;      // responses pile up until the grant stops
    fork
      apply_rows(0, N_ROWS - 1);
      release_when_stalled();
    join
    wait_drained();
    checks++;
    assert (saw_gnt_drop)
    else
    begin
      errors++;
      $display("FAILED at %0t: gnt_o never dropped under back-pressure", $time);
    end

    clear_i = 1'b1;
    @(negedge clk_i);
    checks++;
    assert (empty_o)
    else
    begin
      errors++;
      $display("FAILED at %0t: empty_o low during clear", $time);
    end
    @(posedge clk_i);
    #1;
    clear_i = 1'b0;
    @(negedge clk_i);
    checks++;
    assert (empty_o && gnt_o)
    else
    begin
      errors++;
      $display("FAILED at %0t: after clear empty %b gnt %b", $time, empty_o, gnt_o);
    end
    @(posedge clk_i);
    #1;
    apply_rows(0, 3);
    wait_drained();

    $display("checks %0d, errors %0d", checks + resp_checks, errors + resp_errors);
    if (errors + resp_errors == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout after %0d cycles with %0d of %0d responses received",
             WATCHDOG_CYCLES, rd_idx, sent_count);
    $display("checks %0d, errors %0d", checks + resp_checks, errors + resp_errors);
    $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire
